// File: Bender.yml
package:
  name: apb_subsystem

sources:
  - ahb_pkg.sv
  - apb_pkg.sv
  - ahb_apb_bridge.sv
  - apb_slave_decoder.sv
  - alut_apb_regs.sv
  - alut_table.sv
  - apb_subsystem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_apb_subsystem.sv

// File: ahb_apb_bridge.sv
`timescale 1ns/1ns

module ahb_apb_bridge
   import ahb_pkg::*;
   import apb_pkg::*;
(
   input  logic     hclk,
   input  logic     rst_n,
   input  logic     hsel,
   input  logic     hready_in,
   input  ahb_req_t ahb_req,
   output ahb_rsp_t ahb_rsp,
   output apb_req_t apb_req,
   output logic     psel_en,
   input  logic     unmapped,
   input  apb_rsp_t slave_rsp
);

   // ------------------------------------------------------------
   // State machine
   // ------------------------------------------------------------

   // Error state is the second cycle of the ERROR response
   typedef enum logic [1:0] {
      st_idle,
      st_setup,
      st_access,
      st_error
   } state_t;

   state_t      state;
   state_t      state_nxt;
   logic        trans_valid;
   logic        bridge_ready;
   logic        accept;

   // Captured transfer
   logic [31:0] addr_q;
   logic        write_q;
   logic [31:0] wdata_q;
   logic [31:0] rdata_q;

   // Only NONSEQ and SEQ start an APB transfer
   always_comb begin
      case (ahb_req.htrans)
         htrans_nonseq, htrans_seq: trans_valid = 1'b1;
         htrans_idle, htrans_busy:  trans_valid = 1'b0;
         default:                   trans_valid = 1'b0;
      endcase
   end

   // Ready for a new address phase
   assign bridge_ready = (state == st_idle) || (state == st_error);
   assign accept       = hsel && hready_in && trans_valid && bridge_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (accept)
               state_nxt = st_setup;
         end
         st_setup: begin
            // Decode result is ready from the captured address
            if (unmapped)
               state_nxt = st_error;
            else
               state_nxt = st_access;
         end
         st_access: begin
            // Held here for as long as the slave stalls
            if (slave_rsp.pready)
               state_nxt = st_idle;
         end
         st_error: begin
            // Master may issue the next transfer in this cycle
            if (accept)
               state_nxt = st_setup;
            else
               state_nxt = st_idle;
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge hclk) begin
      if (!rst_n)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   // ------------------------------------------------------------
   // Address, write data and read data capture
   // ------------------------------------------------------------
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= ahb_req.haddr;
         write_q <= ahb_req.hwrite;
      end
      // AHB data phase lines up with APB setup
      if (state == st_setup)
         wdata_q <= ahb_req.hwdata;
      if ((state == st_access) && slave_rsp.pready && !write_q)
         rdata_q <= slave_rsp.prdata;
   end

   // ------------------------------------------------------------
   // APB side
   // ------------------------------------------------------------
   always_comb begin
      apb_req.paddr   = addr_q;
      apb_req.pwrite  = write_q;
      apb_req.penable = (state == st_access);
      // Live hwdata in setup, held copy during access
      apb_req.pwdata  = (state == st_setup) ? ahb_req.hwdata : wdata_q;
   end

   // No select for an unmapped address
   assign psel_en = ((state == st_setup) && !unmapped) || (state == st_access);

   // ------------------------------------------------------------
   // AHB response
   // ------------------------------------------------------------
   always_comb begin
      ahb_rsp.hrdata = rdata_q;
      ahb_rsp.hready = bridge_ready;
      // Two-cycle ERROR, first with hready low
      if ((state == st_error) || ((state == st_setup) && unmapped))
         ahb_rsp.hresp = hresp_error;
      else
         ahb_rsp.hresp = hresp_okay;
   end

endmodule

// File: ahb_pkg.sv
package ahb_pkg;

   // ------------------------------------------------------------
   // AHB-lite transfer types
   // ------------------------------------------------------------

   // No transfer wanted
   localparam logic [1:0] htrans_idle   = 2'b00;
   // Master inserting a wait inside a burst
   localparam logic [1:0] htrans_busy   = 2'b01;
   // First beat or single transfer
   localparam logic [1:0] htrans_nonseq = 2'b10;
   // Following beat of a burst
   localparam logic [1:0] htrans_seq    = 2'b11;

   // Response codes, single bit on AHB-lite
   localparam logic hresp_okay  = 1'b0;
   localparam logic hresp_error = 1'b1;

   // ------------------------------------------------------------
   // Master to slave
   // ------------------------------------------------------------
   typedef struct packed {
      logic [31:0] haddr;
      logic [1:0]  htrans;
      logic        hwrite;
      logic [2:0]  hsize;
      // Data phase, one cycle after haddr
      logic [31:0] hwdata;
   } ahb_req_t;

   // Slave to master
   typedef struct packed {
      logic [31:0] hrdata;
      logic        hready;
      logic        hresp;
   } ahb_rsp_t;

endpackage

// File: alut_apb_regs.sv
`timescale 1ns/1ns

module alut_apb_regs
   import apb_pkg::*;
(
   input  logic        hclk,
   input  logic        rst_n,
   input  logic        psel,
   input  apb_req_t    apb_req,
   output logic [31:0] prdata,
   output logic [47:0] mac_key,
   output logic [2:0]  entry_idx,
   output logic [1:0]  entry_port,
   output logic        commit_stb,
   output logic        lookup_stb,
   output logic        clear_stb,
   input  logic        hit,
   input  logic [1:0]  hit_port
);

   logic [6:0]  offset;
   logic        wr_access;
   logic [31:0] mac_lo_q;
   logic [15:0] mac_hi_q;

   // ------------------------------------------------------------
   // Access decode
   // ------------------------------------------------------------
   assign offset = apb_req.paddr[6:0];

   // Write lands in the access cycle, zero wait
   assign wr_access = psel && apb_req.penable && apb_req.pwrite;

   // ------------------------------------------------------------
   // Staged MAC address
   // ------------------------------------------------------------
   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         mac_lo_q <= '0;
         mac_hi_q <= '0;
      end else if (wr_access) begin
         if (offset == alut_mac_lo)
            mac_lo_q <= apb_req.pwdata;
         // Upper two bytes of the MAC only
         if (offset == alut_mac_hi)
            mac_hi_q <= apb_req.pwdata[15:0];
      end
   end

   assign mac_key = {mac_hi_q, mac_lo_q};

   // ------------------------------------------------------------
   // Table strobes
   // ------------------------------------------------------------

   // Commit data word: index in [4:2], port in [1:0]
   assign entry_idx  = apb_req.pwdata[4:2];
   assign entry_port = apb_req.pwdata[1:0];

   // Single-cycle pulses, table acts on the next edge
   assign commit_stb = wr_access && (offset == alut_commit);
   assign lookup_stb = wr_access && (offset == alut_lookup);
   assign clear_stb  = wr_access && (offset == alut_clear);

   // ------------------------------------------------------------
   // Read mux
   // ------------------------------------------------------------
   always_comb begin
      prdata = '0;
      case (offset)
         alut_mac_lo: begin
            prdata = mac_lo_q;
         end
         alut_mac_hi: begin
            prdata[15:0] = mac_hi_q;
         end
         alut_result: begin
            // Hit flag in bit 8, port in the bottom bits
            prdata[8]   = hit;
            prdata[1:0] = hit_port;
         end
         // Strobe offsets and holes read zero
         default: prdata = '0;
      endcase
   end

endmodule

// File: alut_table.sv
`timescale 1ns/1ns

module alut_table
   import apb_pkg::*;
(
   input  logic        hclk,
   input  logic        rst_n,
   input  logic [47:0] mac_key,
   input  logic [2:0]  entry_idx,
   input  logic [1:0]  entry_port,
   input  logic        commit_stb,
   input  logic        lookup_stb,
   input  logic        clear_stb,
   output logic        hit,
   output logic [1:0]  hit_port
);

   // Per entry: valid flag, MAC, switch port
   logic [alut_entries-1:0] valid_q;
   logic [47:0]             mac_q  [alut_entries];
   logic [1:0]              port_q [alut_entries];

   logic [alut_entries-1:0] match;
   logic [1:0]              match_port;

   // ------------------------------------------------------------
   // Entry storage
   // ------------------------------------------------------------
   always_ff @(posedge hclk) begin
      // Clear drops every entry at once
      if (!rst_n || clear_stb)
         valid_q <= '0;
      else if (commit_stb)
         valid_q[entry_idx] <= 1'b1;
   end

   always_ff @(posedge hclk) begin
      if (commit_stb) begin
         mac_q[entry_idx]  <= mac_key;
         port_q[entry_idx] <= entry_port;
      end
   end

   // ------------------------------------------------------------
   // Parallel search
   // ------------------------------------------------------------
   always_comb begin
      match_port = '0;
      // Walk downward so the lowest index wins
      for (int i = alut_entries - 1; i >= 0; i--) begin
         match[i] = valid_q[i] && (mac_q[i] == mac_key);
         if (match[i])
            match_port = port_q[i];
      end
   end

   // Result held until the next lookup
   always_ff @(posedge hclk) begin
      if (!rst_n) begin
         hit      <= 1'b0;
         hit_port <= '0;
      end else if (lookup_stb) begin
         hit      <= |match;
         hit_port <= match_port;
      end
   end

endmodule

// File: apb_pkg.sv
package apb_pkg;

   // ------------------------------------------------------------
   // Subsystem address map
   // ------------------------------------------------------------

   // ALUT plus four MAC register blocks
   localparam int num_apb_slaves = 5;
   localparam int num_macs       = 4;

   // haddr[31:20] of the whole subsystem
   localparam logic [11:0] apb_base_hi = 12'h00A;

   // Slot from haddr[19:16]; MACs follow in slots 1 to 4
   localparam int alut_slot = 0;

   // Lookup table depth
   localparam int alut_entries = 8;

   // ------------------------------------------------------------
   // ALUT register offsets, paddr[6:0]
   // ------------------------------------------------------------
   localparam logic [6:0] alut_mac_lo  = 7'h00;
   localparam logic [6:0] alut_mac_hi  = 7'h04;
   // Write only, index and port in the data word
   localparam logic [6:0] alut_commit  = 7'h08;
   localparam logic [6:0] alut_lookup  = 7'h0C;
   localparam logic [6:0] alut_result  = 7'h10;
   localparam logic [6:0] alut_clear   = 7'h14;

   // ------------------------------------------------------------
   // APB request and response
   // ------------------------------------------------------------
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      // Low in setup, high in access
      logic        penable;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

endpackage

// File: apb_slave_decoder.sv
`timescale 1ns/1ns

module apb_slave_decoder
   import apb_pkg::*;
(
   input  apb_req_t                  apb_req,
   input  logic                      psel_en,
   output logic [num_apb_slaves-1:0] psel,
   output logic                      unmapped,
   input  logic [31:0]               alut_prdata,
   input  apb_rsp_t                  mac_rsp [num_macs],
   output apb_rsp_t                  slave_rsp
);

   logic [3:0] slot;
   logic       base_hit;

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   assign slot     = apb_req.paddr[19:16];
   assign base_hit = (apb_req.paddr[31:20] == apb_base_hi);

   // Base miss or slots 5 to 15
   assign unmapped = !base_hit || (slot >= num_apb_slaves);

   // One-hot select, only while the bridge is in a transfer
   always_comb begin
      for (int i = 0; i < num_apb_slaves; i++)
         psel[i] = psel_en && !unmapped && (slot == i);
   end

   // ------------------------------------------------------------
   // Response mux
   // ------------------------------------------------------------
   always_comb begin
      // Unmapped reads zero and never stalls
      slave_rsp.prdata = '0;
      slave_rsp.pready = 1'b1;
      if (!unmapped) begin
         if (slot == alut_slot) begin
            // ALUT is always ready
            slave_rsp.prdata = alut_prdata;
         end else begin
            // MAC i sits in slot i + 1
            for (int i = 0; i < num_macs; i++) begin
               if (slot == i + 1)
                  slave_rsp = mac_rsp[i];
            end
         end
      end
   end

endmodule

// File: apb_subsystem.sv
`timescale 1ns/1ns

module apb_subsystem
   import ahb_pkg::*;
   import apb_pkg::*;
(
   input  logic                hclk,
   input  logic                rst_n,
   input  logic                hsel,
   input  logic                hready_in,
   input  ahb_req_t            ahb_req,
   output ahb_rsp_t            ahb_rsp,
   output apb_req_t            apb_req,
   output logic [num_macs-1:0] psel_mac,
   input  apb_rsp_t            mac_rsp [num_macs]
);

   // Bridge to decoder
   logic        psel_en;
   logic        unmapped;
   apb_rsp_t    slave_rsp;

   // ALUT front end
   logic        psel_alut;
   logic [31:0] alut_prdata;

   // Front end to table
   logic [47:0] mac_key;
   logic [2:0]  entry_idx;
   logic [1:0]  entry_port;
   logic        commit_stb;
   logic        lookup_stb;
   logic        clear_stb;
   logic        hit;
   logic [1:0]  hit_port;

   // ------------------------------------------------------------
   // AHB to APB
   // ------------------------------------------------------------
   ahb_apb_bridge u_bridge (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .hready_in (hready_in),
      .ahb_req   (ahb_req),
      .ahb_rsp   (ahb_rsp),
      .apb_req   (apb_req),
      .psel_en   (psel_en),
      .unmapped  (unmapped),
      .slave_rsp (slave_rsp)
   );

   // ALUT in bit 0, MACs above it
   apb_slave_decoder u_decoder (
      .apb_req     (apb_req),
      .psel_en     (psel_en),
      .psel        ({psel_mac, psel_alut}),
      .unmapped    (unmapped),
      .alut_prdata (alut_prdata),
      .mac_rsp     (mac_rsp),
      .slave_rsp   (slave_rsp)
   );

   // ------------------------------------------------------------
   // Address lookup table
   // ------------------------------------------------------------
   alut_apb_regs u_alut_regs (
      .hclk       (hclk),
      .rst_n      (rst_n),
      .psel       (psel_alut),
      .apb_req    (apb_req),
      .prdata     (alut_prdata),
      .mac_key    (mac_key),
      .entry_idx  (entry_idx),
      .entry_port (entry_port),
      .commit_stb (commit_stb),
      .lookup_stb (lookup_stb),
      .clear_stb  (clear_stb),
      .hit        (hit),
      .hit_port   (hit_port)
   );

   alut_table u_alut_table (
      .hclk       (hclk),
      .rst_n      (rst_n),
      .mac_key    (mac_key),
      .entry_idx  (entry_idx),
      .entry_port (entry_port),
      .commit_stb (commit_stb),
      .lookup_stb (lookup_stb),
      .clear_stb  (clear_stb),
      .hit        (hit),
      .hit_port   (hit_port)
   );

endmodule

// File: flist.f
ahb_pkg.sv
apb_pkg.sv
ahb_apb_bridge.sv
apb_slave_decoder.sv
alut_apb_regs.sv
alut_table.sv
apb_subsystem.sv
tb_clock_gen.sv
tb_apb_subsystem.sv

// File: tb_apb_subsystem.sv
`timescale 1ns/1ns

module tb_apb_subsystem
   import ahb_pkg::*;
   import apb_pkg::*;
();

   localparam logic [31:0] rng_seed = 32'hcb4b6b2f;

   // ------------------------------------------------------------
   // Run length and watchdog limit
   // ------------------------------------------------------------
   localparam int num_mac_ops       = 16;
   // Two base misses plus slots 5 to 15
   localparam int num_bad_addrs     = 13;
   // Commits, hit lookups, one stray lookup, clear, lookups after clear
   localparam int num_alut_xfers    = alut_entries * 3 + alut_entries * 4 * 2 + 5;
   localparam int num_xfers         = 2 * num_mac_ops + num_bad_addrs + num_alut_xfers;
   // Gap, address, setup, access with 3 waits, response
   localparam int worst_xfer_cycles = 8;
   localparam int timeout_cycles    = 4 * (16 + num_xfers * worst_xfer_cycles);

   logic     hclk;
   logic     rst_n;
   logic     hsel;
   logic     hready_in;
   ahb_req_t ahb_req;
   ahb_rsp_t ahb_rsp;
   apb_req_t apb_req;
   logic [num_macs-1:0] psel_mac;
   apb_rsp_t mac_rsp [num_macs] = '{default: '0};

   // Expectations for the transfer in flight
   string               cur_name = "";
   logic [31:0]         exp_addr = '0;
   logic                exp_write = 1'b0;
   logic [31:0]         exp_wdata = '0;
   logic [num_macs-1:0] exp_psel = '0;
   logic                exp_unmapped = 1'b0;

   // MAC slave models
   logic [31:0] mac_mem [num_macs][16];
   int          wait_left [num_macs] = '{default: 0};
   int          next_wait = 0;
   logic        sel_pready;

   // Reference model
   logic [31:0] model_mem [num_macs][16];
   logic [alut_entries-1:0] model_valid = '0;
   logic [47:0] model_mac  [alut_entries];
   logic [1:0]  model_port [alut_entries];

   int mismatch_count = 0;
   int fail_count     = 0;
   int cycle_count    = 0;

   tb_clock_gen u_clock_gen (
      .hclk  (hclk),
      .rst_n (rst_n)
   );

   apb_subsystem DUT (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .hready_in (hready_in),
      .ahb_req   (ahb_req),
      .ahb_rsp   (ahb_rsp),
      .apb_req   (apb_req),
      .psel_mac  (psel_mac),
      .mac_rsp   (mac_rsp)
   );

   // ------------------------------------------------------------
   // Address map helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] mac_addr(input int slot, input int word);
      return {apb_base_hi, 4'(slot), 10'h000, 4'(word), 2'b00};
   endfunction

   function automatic logic [31:0] alut_addr(input logic [6:0] offset);
      return {apb_base_hi, 4'(alut_slot), 9'h000, offset};
   endfunction

   // Base miss or slot above the last MAC
   function automatic logic outside_map(input logic [31:0] addr);
      return (addr[31:20] != apb_base_hi) || (addr[19:16] > 4'(num_macs));
   endfunction

   function automatic logic [num_macs-1:0] mac_select(input logic [31:0] addr);
      int slot;
      slot = addr[19:16];
      mac_select = '0;
      if (!outside_map(addr) && slot != alut_slot)
         mac_select[slot - 1] = 1'b1;
   endfunction

   // Power-on word, a function of the full address
   function automatic logic [31:0] fill_word(input int slot, input int word);
      return mac_addr(slot, word) ^ 32'hc3c3_c3c3;
   endfunction

   // Lowest valid matching entry wins
   function automatic logic [31:0] expected_result(input logic [47:0] mac);
      for (int e = 0; e < alut_entries; e++) begin
         if (model_valid[e] && model_mac[e] == mac)
            return {23'h0, 1'b1, 6'h0, model_port[e]};
      end
      return '0;
   endfunction

   // ------------------------------------------------------------
   // MAC slaves, wait states picked by the AHB driver
   // ------------------------------------------------------------
   always @(negedge hclk) begin
      apb_rsp_t rsp;
      for (int i = 0; i < num_macs; i++) begin
         rsp = '0;
         if (psel_mac[i] && !apb_req.penable) begin
            // Setup phase, arm the wait counter
            wait_left[i] = next_wait;
         end else if (psel_mac[i] && apb_req.penable) begin
            if (wait_left[i] == 0) begin
               rsp.pready = 1'b1;
               rsp.prdata = mac_mem[i][apb_req.paddr[5:2]];
            end else begin
               wait_left[i]--;
            end
         end
         mac_rsp[i] <= rsp;
      end
   end

   always @(posedge hclk) begin
      for (int i = 0; i < num_macs; i++) begin
         for (int w = 0; w < 16; w++) begin
            if (!rst_n)
               mac_mem[i][w] <= fill_word(i + 1, w);
         end
         if (rst_n && psel_mac[i] && apb_req.penable && apb_req.pwrite && mac_rsp[i].pready)
            mac_mem[i][apb_req.paddr[5:2]] <= apb_req.pwdata;
      end
   end

   // Ready of whichever MAC is selected
   always_comb begin
      sel_pready = 1'b0;
      for (int i = 0; i < num_macs; i++) begin
         if (psel_mac[i])
            sel_pready = mac_rsp[i].pready;
      end
   end

   // ------------------------------------------------------------
   // Protocol and value assertions
   // ------------------------------------------------------------
   reset_idle: assert property (@(posedge hclk)
      !rst_n |=> ahb_rsp.hready && ahb_rsp.hresp == hresp_okay &&
                 psel_mac == '0 && !apb_req.penable)
   else begin
      fail_count++;
      $display("bridge outputs not idle after reset at %0t", $time);
   end

   psel_target: assert property (@(posedge hclk) disable iff (!rst_n)
      psel_mac == '0 || psel_mac == exp_psel)
   else begin
      mismatch_count++;
      $display("mismatch %s psel_mac: expected %b, actual %b",
               cur_name, $sampled(exp_psel), $sampled(psel_mac));
   end

   apb_address: assert property (@(posedge hclk) disable iff (!rst_n)
      |psel_mac |-> apb_req.paddr == exp_addr && apb_req.pwrite == exp_write)
   else begin
      mismatch_count++;
      $display("mismatch %s apb pwrite and paddr: expected %h, actual %h",
               cur_name, $sampled({exp_write, exp_addr}),
               $sampled({apb_req.pwrite, apb_req.paddr}));
   end

   apb_wdata: assert property (@(posedge hclk) disable iff (!rst_n)
      (|psel_mac && apb_req.penable && apb_req.pwrite) |-> apb_req.pwdata == exp_wdata)
   else begin
      mismatch_count++;
      $display("mismatch %s apb pwdata: expected %h, actual %h",
               cur_name, $sampled(exp_wdata), $sampled(apb_req.pwdata));
   end

   setup_to_access: assert property (@(posedge hclk) disable iff (!rst_n)
      (|psel_mac && !apb_req.penable) |=>
         apb_req.penable && $stable(psel_mac) && $stable(apb_req.paddr))
   else begin
      fail_count++;
      $display("APB setup phase not followed by a matching access phase at %0t", $time);
   end

   // Stalled access keeps penable and the address
   access_hold: assert property (@(posedge hclk) disable iff (!rst_n)
      (|psel_mac && apb_req.penable && !sel_pready) |=>
         apb_req.penable && $stable(psel_mac) && $stable(apb_req.paddr))
   else begin
      fail_count++;
      $display("APB access phase dropped before pready at %0t", $time);
   end

   busy_stall: assert property (@(posedge hclk) disable iff (!rst_n)
      |psel_mac |-> !ahb_rsp.hready)
   else begin
      fail_count++;
      $display("hready high while an APB transfer is open at %0t", $time);
   end

   unmapped_quiet: assert property (@(posedge hclk) disable iff (!rst_n)
      exp_unmapped |-> psel_mac == '0 && !apb_req.penable)
   else begin
      fail_count++;
      $display("APB select or enable raised for an unmapped address at %0t", $time);
   end

   // ------------------------------------------------------------
   // AHB driver
   // ------------------------------------------------------------
   task automatic compare_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      value_match: assert (actual === expected)
      else begin
         mismatch_count++;
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic ahb_transfer(input string name, input logic [31:0] addr, input logic wr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
      int   low_cycles;
      int   exp_low;
      logic exp_resp;
      logic first_resp;
      cur_name     = name;
      exp_psel     = mac_select(addr);
      exp_unmapped = outside_map(addr);
      exp_addr     = addr;
      exp_write    = wr;
      exp_wdata    = wdata;
      if (exp_unmapped) begin
         exp_resp = hresp_error;
         exp_low  = 1;
      end else begin
         exp_resp  = hresp_okay;
         // ALUT never stalls
         next_wait = (exp_psel != '0) ? int'($urandom_range(3, 0)) : 0;
         exp_low   = 2 + next_wait;
      end
      @(negedge hclk);
      hsel           <= 1'b1;
      ahb_req.haddr  <= addr;
      ahb_req.htrans <= htrans_nonseq;
      ahb_req.hwrite <= wr;
      ahb_req.hsize  <= 3'b010;
      @(negedge hclk);
      // Data phase
      hsel           <= 1'b0;
      ahb_req.htrans <= htrans_idle;
      ahb_req.hwdata <= wdata;
      first_resp = ahb_rsp.hresp;
      low_cycles = 0;
      while (!ahb_rsp.hready) begin
         low_cycles++;
         @(negedge hclk);
      end
      rdata = ahb_rsp.hrdata;
      compare_word({name, " first hresp"}, 32'(exp_resp), 32'(first_resp));
      compare_word({name, " hresp"}, 32'(exp_resp), 32'(ahb_rsp.hresp));
      compare_word({name, " wait cycles"}, exp_low, low_cycles);
   endtask

   task automatic ahb_write(input string name, input logic [31:0] addr,
                            input logic [31:0] data);
      logic [31:0] unused;
      ahb_transfer(name, addr, 1'b1, data, unused);
   endtask

   task automatic ahb_read(input string name, input logic [31:0] addr,
                           output logic [31:0] data);
      ahb_transfer(name, addr, 1'b0, $urandom, data);
   endtask

   // ------------------------------------------------------------
   // Test sequences
   // ------------------------------------------------------------
   task automatic mac_test();
      logic [31:0] addr_q [$];
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] rdata;
      int          slot;
      for (int n = 0; n < num_mac_ops; n++) begin
         slot = $urandom_range(num_macs, 1);
         addr = mac_addr(slot, $urandom_range(15, 0));
         data = $urandom;
         ahb_write("mac write", addr, data);
         model_mem[slot - 1][addr[5:2]] = data;
         addr_q.push_back(addr);
      end
      foreach (addr_q[k]) begin
         slot = addr_q[k][19:16];
         ahb_read("mac read", addr_q[k], rdata);
         compare_word("mac read data", model_mem[slot - 1][addr_q[k][5:2]], rdata);
      end
   endtask

   task automatic unmapped_test();
      logic [31:0] rdata;
      // Base misses that carry a MAC slot number
      ahb_read("base miss low", 32'h0011_0040, rdata);
      ahb_write("base miss high", 32'hfff2_0000, 32'h1234_5678);
      for (int s = num_apb_slaves; s < 16; s++) begin
         if (s % 2 == 0)
            ahb_read("bad slot read", mac_addr(s, s), rdata);
         else
            ahb_write("bad slot write", mac_addr(s, s), $urandom);
      end
   endtask

   task automatic stage_mac(input logic [47:0] mac);
      ahb_write("alut mac_lo", alut_addr(alut_mac_lo), mac[31:0]);
      ahb_write("alut mac_hi", alut_addr(alut_mac_hi), {16'h0000, mac[47:32]});
   endtask

   task automatic lookup_check(input string name, input logic [47:0] mac);
      logic [31:0] expected;
      logic [31:0] rdata;
      stage_mac(mac);
      ahb_write({name, " lookup"}, alut_addr(alut_lookup), 32'h0);
      ahb_read({name, " read"}, alut_addr(alut_result), rdata);
      expected = expected_result(mac);
      // A miss only defines the hit flag
      if (expected[8])
         compare_word({name, " result"}, expected, rdata);
      else
         compare_word({name, " hit flag"}, 32'h0, rdata & 32'h100);
   endtask

   task automatic alut_test();
      logic [47:0] macs [alut_entries];
      logic [47:0] stray;
      logic [31:0] hi;
      logic [1:0]  port;
      for (int e = 0; e < alut_entries; e++) begin
         hi      = $urandom;
         macs[e] = {hi[15:0], 32'($urandom)};
         port    = 2'($urandom_range(3, 0));
         stage_mac(macs[e]);
         ahb_write("alut commit", alut_addr(alut_commit), {27'h0, 3'(e), port});
         model_valid[e] = 1'b1;
         model_mac[e]   = macs[e];
         model_port[e]  = port;
      end
      for (int e = 0; e < alut_entries; e++)
         lookup_check("alut hit", macs[e]);
      hi    = $urandom;
      stray = {hi[15:0], 32'($urandom)};
      lookup_check("alut stray", stray);
      ahb_write("alut clear", alut_addr(alut_clear), 32'h0);
      model_valid = '0;
      for (int e = 0; e < alut_entries; e++)
         lookup_check("alut cleared", macs[e]);
   endtask

   // ------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------
   initial begin
      void'($urandom(rng_seed));
      hsel      = 1'b0;
      hready_in = 1'b1;
      ahb_req   = '0;
      for (int i = 0; i < num_macs; i++) begin
         for (int w = 0; w < 16; w++)
            model_mem[i][w] = fill_word(i + 1, w);
      end
      wait (rst_n);
      mac_test();
      unmapped_test();
      alut_test();
      repeat (4) @(negedge hclk);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   always @(posedge hclk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles with transfers still pending", cycle_count);
         $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic hclk,
   output logic rst_n
);

   // 4 ns period
   localparam int half_period  = 2;
   // Rising edges seen with reset low
   localparam int reset_cycles = 16;

   initial begin
      hclk = 1'b0;
      forever #half_period hclk = ~hclk;
   end

   // Released on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge hclk);
      @(negedge hclk);
      rst_n = 1'b1;
   end

endmodule
